//--- tb/system_trace.txt
# name instr pc rs1_data irq_delay exp_exception exp_trap_cause exp_result exp_is_xret exp_priv
# All fields hex except irq_delay, which is decimal cycles after req (0 means no interrupt)
csrrw_mtvec 305110f3 00001000 00000100 0 0 0 00000000 0 3
csrrw_mscratch 340110f3 00001004 a5a500f0 0 0 0 00000000 0 3
csrrs_mscratch 340221f3 00001008 0000000f 0 0 0 a5a500f0 0 3
csrrc_mscratch 340231f3 0000100c a5000000 0 0 0 a5a500ff 0 3
csrrwi_mscratch 340ad2f3 00001010 00000000 0 0 0 00a500ff 0 3
csrrs_read_mscratch 34002373 00001014 00000000 0 0 0 00000015 0 3
csr_unknown_addr 7c0020f3 00001018 00000000 0 1 2 00000100 0 3
ecall_machine 00000073 00001040 00000000 0 1 b 00000100 0 3
read_mepc_ecall 341020f3 00001044 00000000 0 0 0 00001040 0 3
read_mcause_ecall 342020f3 00001048 00000000 0 0 0 0000000b 0 3
ebreak 00100073 00001050 00000000 0 1 3 00000100 0 3
read_mepc_ebreak 341020f3 00001054 00000000 0 0 0 00001050 0 3
read_mcause_ebreak 342020f3 00001058 00000000 0 0 0 00000003 0 3
csrrw_mepc 341110f3 0000105c 00002000 0 0 0 00001050 0 3
csrrc_mstatus_mpp 300130f3 00001060 00001800 0 0 0 00001800 0 3
mret_to_user 30200073 00001064 00000000 0 0 0 00002000 1 0
ecall_user 00000073 00002000 00000000 0 1 8 00000100 0 3
read_mcause_user 342020f3 00000100 00000000 0 0 0 00000008 0 3
read_mstatus_mpp 300020f3 00000104 00000000 0 0 0 00000000 0 3
mret_to_user_2 30200073 00000108 00000000 0 0 0 00002000 1 0
csr_in_user 340020f3 00002004 00000000 0 1 2 00000100 0 3
mret_to_user_3 30200073 0000010c 00000000 0 0 0 00002004 1 0
mret_in_user 30200073 00002008 00000000 0 1 2 00000100 0 3
mret_to_user_4 30200073 00000110 00000000 0 0 0 00002008 1 0
wfi_in_user 10500073 0000200c 00000000 0 1 2 00000100 0 3
wfi_machine 10500073 00000114 00000000 10 0 0 00000000 0 3
sret_illegal 10200073 00000118 00000000 0 1 2 00000100 0 3
hlv_illegal 680140f3 0000011c 00000000 0 1 2 00000100 0 3
non_system 00100093 00000120 00000000 0 1 2 00000100 0 3
sfence_vma 12000073 00000124 00000000 0 0 0 00000000 0 3

//--- sources.f
verilog/sys_pkg.sv
verilog/system_decode.sv
verilog/exec_system.sv
verilog/csr_file.sv
verilog/system_result.sv
verilog/system_unit_top.sv
tb/clock_gen.sv
tb/system_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the system unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module system_unit_tb \
    -Mdir obj_dir -o system_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/system_unit_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    echo "FAIL"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "PASS"
exit 0

//--- tb/system_unit_tb.sv
`default_nettype none

module system_unit_tb;

    localparam int ACK_TIMEOUT = 50;
    localparam int RESET_CYCLES = 3;

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic        interrupt;
    logic        ack;
    logic        exception;
    logic [3:0]  trap_cause;
    logic [31:0] result;
    logic        is_xret;
    logic [1:0]  priv;

    // Trace fields, one line at a time
    int          fd;
    int          code;
    int          n_fields;
    int          tests_run;
    string       line;
    string       t_name;
    logic [31:0] t_instr;
    logic [31:0] t_pc;
    logic [31:0] t_rs1;
    int          t_delay;
    logic [31:0] e_exc;
    logic [31:0] e_cause;
    logic [31:0] e_result;
    logic [31:0] e_xret;
    logic [31:0] e_priv;

    clock_gen #(.PERIOD(100)) u_clock_gen (
        .clk (clk)
    );

    system_unit_top #(.XLEN(32)) u_system_unit_top (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .instr      (instr),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .interrupt  (interrupt),
        .ack        (ack),
        .exception  (exception),
        .trap_cause (trap_cause),
        .result     (result),
        .is_xret    (is_xret),
        .priv       (priv)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR %s: %s expected %h actual %h",
                                        test_name, field, expected, actual));
        end
    endtask

    // One full four-phase handshake with checks on ack and after release
    task automatic run_test(input string name, input logic [31:0] ins, input logic [31:0] pcv,
                            input logic [31:0] rs1v, input int irq_delay,
                            input logic [31:0] exp_exc, input logic [31:0] exp_cause,
                            input logic [31:0] exp_result, input logic [31:0] exp_xret,
                            input logic [31:0] exp_priv);
        int   cycles;
        logic irq_raised;
        cycles = 0;
        irq_raised = 1'b0;
        @(posedge clk);
        req      <= 1'b1;
        instr    <= ins;
        pc       <= pcv;
        rs1_data <= rs1v;
        while (ack !== 1'b1) begin
            @(posedge clk);
            if (irq_delay > 0 && cycles == irq_delay) begin
                interrupt <= 1'b1;  // Held until ack is seen
                irq_raised = 1'b1;
            end
            @(negedge clk);
            cycles++;
            if (ack === 1'b1 && irq_delay > 0 && !irq_raised)
                stop_with_failure($sformatf("%s: ack rose before the interrupt", name));
            if (cycles > ACK_TIMEOUT)
                stop_with_failure($sformatf("%s: timed out waiting for ack to rise", name));
        end
        check_value(name, "exception", exp_exc, {31'd0, exception});
        check_value(name, "trap_cause", exp_cause, {28'd0, trap_cause});
        check_value(name, "result", exp_result, result);
        check_value(name, "is_xret", exp_xret, {31'd0, is_xret});
        @(posedge clk);
        req       <= 1'b0;
        interrupt <= 1'b0;
        cycles = 0;
        while (ack !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT)
                stop_with_failure($sformatf("%s: timed out waiting for ack to fall", name));
        end
        // Trap or return has been committed by now
        check_value(name, "priv", exp_priv, {30'd0, priv});
        tests_run++;
    endtask

    initial begin
        rst       <= 1'b1;
        req       <= 1'b0;
        instr     <= '0;
        pc        <= '0;
        rs1_data  <= '0;
        interrupt <= 1'b0;
        tests_run = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("tb/system_trace.txt", "r");
        if (fd == 0)
            stop_with_failure("could not open the trace file tb/system_trace.txt");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0)
                break;
            if (line.len() > 0 && line.getc(0) != 8'h23) begin  // Skip # lines
                n_fields = $sscanf(line, "%s %h %h %h %d %h %h %h %h %h", t_name, t_instr,
                                   t_pc, t_rs1, t_delay, e_exc, e_cause, e_result,
                                   e_xret, e_priv);
                if (n_fields == 10)
                    run_test(t_name, t_instr, t_pc, t_rs1, t_delay, e_exc, e_cause,
                             e_result, e_xret, e_priv);
                else if (n_fields > 0)
                    stop_with_failure($sformatf("malformed trace line: %s", line));
            end
        end
        $fclose(fd);

        if (tests_run == 0) begin
            stop_with_failure("the trace file held no tests");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`default_nettype none

module clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;  // Half period high, half low
    end

endmodule

`default_nettype wire

//--- verilog/system_unit_top.sv
`default_nettype none

module system_unit_top #(
    parameter int XLEN = 32
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    req,
    input  wire [31:0]             instr,
    input  wire [XLEN-1:0]         pc,
    input  wire [XLEN-1:0]         rs1_data,
    input  wire                    interrupt,
    output logic                   ack,
    output logic                   exception,
    output sys_pkg::trap_cause_e   trap_cause,
    output logic [XLEN-1:0]        result,
    output logic                   is_xret,
    output sys_pkg::priv_e         priv
);

    logic                 dec_valid;
    sys_pkg::sys_op_e     op;
    logic [XLEN-1:0]      dec_pc;
    logic [XLEN-1:0]      dec_rs1_data;
    logic [11:0]          dec_csr_addr;
    logic [2:0]           dec_funct3;
    logic [4:0]           dec_rd;
    logic [4:0]           dec_rs1;

    logic                 csr_req;
    logic [11:0]          csr_addr;
    logic [2:0]           csr_funct3;
    logic [4:0]           csr_uimm;
    logic [XLEN-1:0]      csr_wdata;
    logic [XLEN-1:0]      csr_rdata;
    logic                 csr_illegal;
    logic [XLEN-1:0]      mepc;
    logic [XLEN-1:0]      mtvec;

    logic                 ex_valid;
    logic                 ex_exception;
    sys_pkg::trap_cause_e ex_trap_cause;
    logic [XLEN-1:0]      ex_result;
    logic                 ex_is_xret;
    logic                 ex_is_wfi;
    logic [XLEN-1:0]      ex_pc;

    logic                 commit_trap;
    logic [XLEN-1:0]      trap_pc;
    sys_pkg::trap_cause_e commit_trap_cause;
    logic                 commit_mret;

    system_decode #(.XLEN(XLEN)) u_decode (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .instr        (instr),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .dec_valid    (dec_valid),
        .op           (op),
        .dec_pc       (dec_pc),
        .dec_rs1_data (dec_rs1_data),
        .csr_addr     (dec_csr_addr),
        .funct3       (dec_funct3),
        .rd           (dec_rd),
        .rs1          (dec_rs1)
    );

    exec_system #(.XLEN(XLEN)) u_exec (
        .clk           (clk),
        .rst           (rst),
        .dec_valid     (dec_valid),
        .op            (op),
        .dec_pc        (dec_pc),
        .dec_rs1_data  (dec_rs1_data),
        .csr_addr      (dec_csr_addr),
        .funct3        (dec_funct3),
        .rd            (dec_rd),
        .rs1           (dec_rs1),
        .csr_rdata     (csr_rdata),
        .csr_illegal   (csr_illegal),
        .priv          (priv),
        .mepc          (mepc),
        .mtvec         (mtvec),
        .csr_req       (csr_req),
        .csr_addr_o    (csr_addr),
        .csr_funct3    (csr_funct3),
        .csr_uimm      (csr_uimm),
        .csr_wdata     (csr_wdata),
        .ex_valid      (ex_valid),
        .ex_exception  (ex_exception),
        .ex_trap_cause (ex_trap_cause),
        .ex_result     (ex_result),
        .ex_is_xret    (ex_is_xret),
        .ex_is_wfi     (ex_is_wfi),
        .ex_pc         (ex_pc)
    );

    csr_file #(.XLEN(XLEN)) u_csr (
        .clk         (clk),
        .rst         (rst),
        .csr_req     (csr_req),
        .csr_addr    (csr_addr),
        .csr_funct3  (csr_funct3),
        .csr_uimm    (csr_uimm),
        .csr_wdata   (csr_wdata),
        .commit_trap (commit_trap),
        .trap_pc     (trap_pc),
        .trap_cause  (commit_trap_cause),
        .commit_mret (commit_mret),
        .csr_rdata   (csr_rdata),
        .csr_illegal (csr_illegal),
        .priv        (priv),
        .mepc        (mepc),
        .mtvec       (mtvec)
    );

    system_result #(.XLEN(XLEN)) u_result (
        .clk               (clk),
        .rst               (rst),
        .req               (req),
        .interrupt         (interrupt),
        .ex_valid          (ex_valid),
        .ex_exception      (ex_exception),
        .ex_trap_cause     (ex_trap_cause),
        .ex_result         (ex_result),
        .ex_is_xret        (ex_is_xret),
        .ex_is_wfi         (ex_is_wfi),
        .ex_pc             (ex_pc),
        .ack               (ack),
        .exception         (exception),
        .trap_cause        (trap_cause),
        .result            (result),
        .is_xret           (is_xret),
        .commit_trap       (commit_trap),
        .trap_pc           (trap_pc),
        .commit_trap_cause (commit_trap_cause),
        .commit_mret       (commit_mret)
    );

endmodule

`default_nettype wire

//--- verilog/system_result.sv
`default_nettype none

module system_result #(
    parameter int XLEN = 32
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        req,
    input  wire                        interrupt,
    input  wire                        ex_valid,
    input  wire                        ex_exception,
    input  wire sys_pkg::trap_cause_e  ex_trap_cause,
    input  wire [XLEN-1:0]             ex_result,
    input  wire                        ex_is_xret,
    input  wire                        ex_is_wfi,
    input  wire [XLEN-1:0]             ex_pc,
    output logic                       ack,
    output logic                       exception,
    output sys_pkg::trap_cause_e       trap_cause,
    output logic [XLEN-1:0]            result,
    output logic                       is_xret,
    output logic                       commit_trap,
    output logic [XLEN-1:0]            trap_pc,
    output sys_pkg::trap_cause_e       commit_trap_cause,
    output logic                       commit_mret
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_WFI,
        ACKED,
        RELEASE
    } state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            ack         <= 1'b0;
            commit_trap <= 1'b0;
            commit_mret <= 1'b0;
        end else begin
            commit_trap <= 1'b0;  // Pulses only
            commit_mret <= 1'b0;
            case (state)
                IDLE: begin
                    if (ex_valid) begin
                        if (ex_is_wfi && !interrupt) begin
                            state <= WAIT_WFI;
                        end else begin
                            state       <= ACKED;
                            ack         <= 1'b1;
                            commit_trap <= ex_exception;
                            commit_mret <= ex_is_xret;
                        end
                    end
                end
                WAIT_WFI: begin
                    if (interrupt) begin
                        state <= ACKED;
                        ack   <= 1'b1;
                    end
                end
                ACKED: begin
                    if (!req) begin
                        state <= RELEASE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= IDLE;  // RELEASE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && ex_valid) begin
            exception         <= ex_exception;
            trap_cause        <= ex_trap_cause;
            result            <= ex_result;
            is_xret           <= ex_is_xret;
            trap_pc           <= ex_pc;
            commit_trap_cause <= ex_trap_cause;
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_file.sv
`default_nettype none

module csr_file #(
    parameter int XLEN = 32
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        csr_req,
    input  wire [11:0]                 csr_addr,
    input  wire [2:0]                  csr_funct3,
    input  wire [4:0]                  csr_uimm,
    input  wire [XLEN-1:0]             csr_wdata,
    input  wire                        commit_trap,
    input  wire [XLEN-1:0]             trap_pc,
    input  wire sys_pkg::trap_cause_e  trap_cause,
    input  wire                        commit_mret,
    output logic [XLEN-1:0]            csr_rdata,
    output logic                       csr_illegal,
    output sys_pkg::priv_e             priv,
    output logic [XLEN-1:0]            mepc,
    output logic [XLEN-1:0]            mtvec
);

    localparam int MPP = sys_pkg::MSTATUS_MPP_LSB;

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mscratch;
    logic            known;
    logic [XLEN-1:0] src;
    logic [XLEN-1:0] new_val;
    logic            do_write;
    logic            wr_en;
    logic [1:0]      mpp;

    assign mpp = mstatus[MPP +: 2];

    always_comb begin
        known     = 1'b1;
        csr_rdata = '0;
        case (csr_addr)
            sys_pkg::CSR_MSTATUS:  csr_rdata = mstatus;
            sys_pkg::CSR_MTVEC:    csr_rdata = mtvec;
            sys_pkg::CSR_MEPC:     csr_rdata = mepc;
            sys_pkg::CSR_MCAUSE:   csr_rdata = mcause;
            sys_pkg::CSR_MSCRATCH: csr_rdata = mscratch;
            default:               known = 1'b0;
        endcase
    end

    // Every CSR held here is machine level and writable
    assign csr_illegal = !known || priv == sys_pkg::USER;

    // funct3[2] picks the zero-extended immediate
    assign src = csr_funct3[2] ? {{(XLEN-5){1'b0}}, csr_uimm} : csr_wdata;

    always_comb begin
        new_val  = src;
        do_write = 1'b1;
        case (csr_funct3[1:0])
            2'b01: new_val = src;  // RW
            2'b10: begin           // RS
                new_val  = csr_rdata | src;
                do_write = src != '0;
            end
            2'b11: begin           // RC
                new_val  = csr_rdata & ~src;
                do_write = src != '0;
            end
            default: do_write = 1'b0;
        endcase
    end

    assign wr_en = csr_req && !csr_illegal && do_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv     <= sys_pkg::MACHINE;
            mstatus  <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (commit_trap) begin
            mepc            <= trap_pc;
            mcause          <= {{(XLEN-4){1'b0}}, trap_cause};
            mstatus[MPP +: 2] <= priv;
            priv            <= sys_pkg::MACHINE;
        end else if (commit_mret) begin
            // Only U and M exist, anything else in MPP returns to user
            priv              <= (mpp == sys_pkg::MACHINE) ? sys_pkg::MACHINE : sys_pkg::USER;
            mstatus[MPP +: 2] <= sys_pkg::USER;
        end else if (wr_en) begin
            case (csr_addr)
                sys_pkg::CSR_MSTATUS:  mstatus  <= new_val;
                sys_pkg::CSR_MTVEC:    mtvec    <= new_val;
                sys_pkg::CSR_MEPC:     mepc     <= new_val;
                sys_pkg::CSR_MCAUSE:   mcause   <= new_val;
                sys_pkg::CSR_MSCRATCH: mscratch <= new_val;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/exec_system.sv
`default_nettype none

module exec_system #(
    parameter int XLEN = 32
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      dec_valid,
    input  wire sys_pkg::sys_op_e    op,
    input  wire [XLEN-1:0]           dec_pc,
    input  wire [XLEN-1:0]           dec_rs1_data,
    input  wire [11:0]               csr_addr,
    input  wire [2:0]                funct3,
    input  wire [4:0]                rd,
    input  wire [4:0]                rs1,
    input  wire [XLEN-1:0]           csr_rdata,
    input  wire                      csr_illegal,
    input  wire sys_pkg::priv_e      priv,
    input  wire [XLEN-1:0]           mepc,
    input  wire [XLEN-1:0]           mtvec,
    output logic                     csr_req,
    output logic [11:0]              csr_addr_o,
    output logic [2:0]               csr_funct3,
    output logic [4:0]               csr_uimm,
    output logic [XLEN-1:0]          csr_wdata,
    output logic                     ex_valid,
    output logic                     ex_exception,
    output sys_pkg::trap_cause_e     ex_trap_cause,
    output logic [XLEN-1:0]          ex_result,
    output logic                     ex_is_xret,
    output logic                     ex_is_wfi,
    output logic [XLEN-1:0]          ex_pc
);

    logic                 exc;
    sys_pkg::trap_cause_e cause;
    logic                 xret;
    logic                 wfi;
    logic [XLEN-1:0]      res;

    // CSR access goes out in the dec_valid cycle, csr_file answers combinationally
    assign csr_req    = dec_valid && op == sys_pkg::SYS_CSR;
    assign csr_addr_o = csr_addr;
    assign csr_funct3 = funct3;
    assign csr_uimm   = rs1;
    assign csr_wdata  = dec_rs1_data;

    always_comb begin
        exc   = 1'b0;
        cause = sys_pkg::EXC_ILLEGAL_INSTR;
        xret  = 1'b0;
        wfi   = 1'b0;
        case (op)
            sys_pkg::SYS_CSR: exc = csr_illegal;
            sys_pkg::SYS_ECALL: begin
                exc   = 1'b1;
                cause = (priv == sys_pkg::USER) ? sys_pkg::EXC_ENV_CALL_UMODE
                                                : sys_pkg::EXC_ENV_CALL_MMODE;
            end
            sys_pkg::SYS_EBREAK: begin
                exc   = 1'b1;
                cause = sys_pkg::EXC_BREAKPOINT;
            end
            sys_pkg::SYS_MRET: begin
                exc  = priv != sys_pkg::MACHINE;
                xret = priv == sys_pkg::MACHINE;
            end
            sys_pkg::SYS_WFI: begin
                exc = priv == sys_pkg::USER;  // TW not modelled, only user traps
                wfi = priv != sys_pkg::USER;
            end
            sys_pkg::SYS_SFENCE: ;  // No paging, nothing to flush
            default: exc = 1'b1;    // SRET/URET, HLS and bad encodings
        endcase
    end

    always_comb begin
        if (exc)
            res = mtvec;  // Trap target
        else if (xret)
            res = mepc;
        else if (op == sys_pkg::SYS_CSR && rd != 5'd0)
            res = csr_rdata;  // Old value, dropped when rd is x0
        else
            res = '0;
    end

    always_ff @(posedge clk) begin
        if (rst)
            ex_valid <= 1'b0;
        else
            ex_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_exception  <= exc;
            ex_trap_cause <= exc ? cause : sys_pkg::trap_cause_e'(4'd0);
            ex_result     <= res;
            ex_is_xret    <= xret;
            ex_is_wfi     <= wfi;
            ex_pc         <= dec_pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/system_decode.sv
`default_nettype none

module system_decode #(
    parameter int XLEN = 32
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    req,
    input  wire [31:0]             instr,
    input  wire [XLEN-1:0]         pc,
    input  wire [XLEN-1:0]         rs1_data,
    output logic                   dec_valid,
    output sys_pkg::sys_op_e       op,
    output logic [XLEN-1:0]        dec_pc,
    output logic [XLEN-1:0]        dec_rs1_data,
    output logic [11:0]            csr_addr,
    output logic [2:0]             funct3,
    output logic [4:0]             rd,
    output logic [4:0]             rs1
);

    logic req_q;
    logic start;
    sys_pkg::sys_op_e op_next;

    wire [4:0] opcode_f = instr[6:2];
    wire [4:0] rd_f     = instr[11:7];
    wire [2:0] funct3_f = instr[14:12];
    wire [4:0] rs1_f    = instr[19:15];
    wire [4:0] rs2_f    = instr[24:20];
    wire [6:0] funct7_f = instr[31:25];

    assign start = req && !req_q;  // Rising edge of req

    always_comb begin
        op_next = sys_pkg::SYS_ILLEGAL;
        if (opcode_f == sys_pkg::OPC_SYSTEM) begin
            if (funct3_f == 3'b100)
                op_next = sys_pkg::SYS_HLS;
            else if (funct3_f != 3'b000)
                op_next = sys_pkg::SYS_CSR;
            else if (funct7_f == 7'b0001001)
                op_next = sys_pkg::SYS_SFENCE;
            else if (rs1_f == 5'd0 && rd_f == 5'd0) begin
                case ({funct7_f, rs2_f})
                    {7'b0000000, 5'b00000}: op_next = sys_pkg::SYS_ECALL;
                    {7'b0000000, 5'b00001}: op_next = sys_pkg::SYS_EBREAK;
                    {7'b0011000, 5'b00010}: op_next = sys_pkg::SYS_MRET;
                    {7'b0001000, 5'b00010},
                    {7'b0000000, 5'b00010}: op_next = sys_pkg::SYS_XRET_LOW;
                    {7'b0001000, 5'b00101}: op_next = sys_pkg::SYS_WFI;
                    default:                op_next = sys_pkg::SYS_ILLEGAL;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q     <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            req_q     <= req;
            dec_valid <= start;
        end
    end

    // Fields held until the next request
    always_ff @(posedge clk) begin
        if (start) begin
            op           <= op_next;
            dec_pc       <= pc;
            dec_rs1_data <= rs1_data;
            csr_addr     <= instr[31:20];
            funct3       <= funct3_f;
            rd           <= rd_f;
            rs1          <= rs1_f;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sys_pkg.sv
`default_nettype none

package sys_pkg;

    // Major opcode field, instr[6:2]
    typedef enum logic [4:0] {
        OPC_SYSTEM = 5'b11100
    } opcode_e;

    // Operation class decided by the decode stage
    typedef enum logic [3:0] {
        SYS_CSR      = 4'd0,
        SYS_ECALL    = 4'd1,
        SYS_EBREAK   = 4'd2,
        SYS_MRET     = 4'd3,
        SYS_XRET_LOW = 4'd4,  // SRET and URET
        SYS_WFI      = 4'd5,
        SYS_SFENCE   = 4'd6,
        SYS_HLS      = 4'd7,  // Hypervisor load/store
        SYS_ILLEGAL  = 4'd8
    } sys_op_e;

    typedef enum logic [1:0] {
        USER    = 2'd0,
        MACHINE = 2'd3
    } priv_e;

    // Exception codes as written to mcause
    typedef enum logic [3:0] {
        EXC_ILLEGAL_INSTR  = 4'd2,
        EXC_BREAKPOINT     = 4'd3,
        EXC_ENV_CALL_UMODE = 4'd8,
        EXC_ENV_CALL_MMODE = 4'd11
    } trap_cause_e;

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    // MPP occupies mstatus[12:11]
    localparam int MSTATUS_MPP_LSB = 11;

endpackage

`default_nettype wire
